// ==== logic/vidc_settings.svh ====
// VIDC capture widths, counts and register addresses
// Addresses are the word index of the VIDC register (byte offset / 4)
`ifndef VIDC_SETTINGS_SVH
`define VIDC_SETTINGS_SVH

`define VIDC_DATA_W              32
`define VIDC_ADDR_W              6
`define VIDC_REG_DATA_W          24
`define VIDC_SYNC_STAGES         3
`define VIDC_DMA_BEATS           4
`define VIDC_NUM_COLOURS         16
`define VIDC_NUM_CURSOR_COLOURS  3

`define VIDC_ADDR_BORDER  6'h10
`define VIDC_ADDR_CPLC1   6'h11   // Cursor colours 1 to 3 follow
`define VIDC_ADDR_HCR     6'h20
`define VIDC_ADDR_HCSR    6'h26
`define VIDC_ADDR_VCR     6'h28
`define VIDC_ADDR_VDSR    6'h2B
`define VIDC_ADDR_VCSR    6'h2E
`define VIDC_ADDR_VCER    6'h2F

`endif

// ==== logic/vidc_reg_pkg.sv ====
// Register-side types for the VIDC capture
// Pin bus word, register address and payload, and the mirror field types
`include "vidc_settings.svh"

package vidc_reg_pkg;

   // Raw word on the VIDC data pins
   typedef logic [`VIDC_DATA_W-1:0] bus_word_t;

   // Register write word splits into address and payload
   typedef logic [`VIDC_ADDR_W-1:0]     reg_addr_t;
   typedef logic [`VIDC_REG_DATA_W-1:0] reg_data_t;

   ////////////////////////////////////////////////////////////////////////////
   // Mirror fields

   typedef logic [11:0] colour_t;     // Supremacy bit not kept
   typedef logic [9:0]  timing_t;     // Horizontal and vertical timing regs
   typedef logic [12:0] hcursor_t;    // HCSR keeps two extra fine bits
   typedef logic [10:0] cursor_x_t;

endpackage

// ==== logic/vidc_dma_pkg.sv ====
// DMA-side types for the VIDC capture
// Burst tracker state, beat counter and per-frame counters
`include "vidc_settings.svh"

package vidc_dma_pkg;

   typedef enum logic [1:0] {
      dma_idle,
      dma_video,
      dma_cursor
   } dma_state_t;

   typedef logic [2:0]  beat_count_t;
   typedef logic [15:0] dma_count_t;     // Bursts seen in one frame
   typedef logic [3:0]  frame_count_t;

endpackage

// ==== logic/sample_if.sv ====
// Sampled and edge-detected VIDC pin events
// Driven by one sampler and read by the register mirror and DMA tracker

interface sample_if;

   logic                    reg_write;     // One cycle per write strobe
   vidc_reg_pkg::reg_addr_t reg_addr;
   vidc_reg_pkg::reg_data_t reg_data;
   vidc_reg_pkg::bus_word_t dma_data;      // One stage older than reg_data
   logic                    hs;            // High outside horizontal sync
   logic                    vdrq;          // Low while DMA requested
   logic                    vdak_rise;
   logic                    flybk_start;

   modport sampler (output reg_write, reg_addr, reg_data, dma_data,
                    output hs, vdrq, vdak_rise, flybk_start);

   modport mirror (input reg_write, reg_addr, reg_data);

   modport tracker (input hs, vdrq, vdak_rise, flybk_start, dma_data);

endinterface

// ==== logic/pin_sampler.sv ====
// VIDC pin synchronisers, data history and edge detection
`include "vidc_settings.svh"

module pin_sampler (
   input  logic                    clk,
   input  logic                    reset,
   input  vidc_reg_pkg::bus_word_t vidc_d,
   input  logic                    vidc_nvidw,
   input  logic                    vidc_nhs,
   input  logic                    vidc_flybk,
   input  logic                    vidc_nvidrq,
   input  logic                    vidc_nvidak,
   sample_if.sampler               bus
);

   typedef struct packed {
      logic nvidw;
      logic nhs;
      logic flybk;
      logic nvidrq;
      logic nvidak;
   } pins_t;

   localparam int cur = 1;                        // First stage safe to use
   localparam int prev = `VIDC_SYNC_STAGES - 1;

   pins_t                   pin_hist [`VIDC_SYNC_STAGES];
   vidc_reg_pkg::bus_word_t d_hist [`VIDC_SYNC_STAGES];

   // Strobe and sync histories idle high so no edge is seen out of reset
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `VIDC_SYNC_STAGES; i++)
            pin_hist[i] <= '1;
      end else begin
         pin_hist[0] <= '{vidc_nvidw, vidc_nhs, vidc_flybk, vidc_nvidrq, vidc_nvidak};
         for (int i = 1; i < `VIDC_SYNC_STAGES; i++)
            pin_hist[i] <= pin_hist[i-1];
      end
   end

   // Data pipeline kept in step with the strobes
   always_ff @(posedge clk) begin
      d_hist[0] <= vidc_d;
      for (int i = 1; i < `VIDC_SYNC_STAGES; i++)
         d_hist[i] <= d_hist[i-1];
   end

   ////////////////////////////////////////////////////////////////////////////
   // Events

   assign bus.reg_write   = pin_hist[prev].nvidw & ~pin_hist[cur].nvidw;   // Falling edge
   assign bus.reg_addr    = d_hist[cur][`VIDC_DATA_W-1 -: `VIDC_ADDR_W];
   assign bus.reg_data    = d_hist[cur][`VIDC_REG_DATA_W-1:0];
   assign bus.dma_data    = d_hist[prev];    // Ack edge is seen a stage late
   assign bus.hs          = pin_hist[cur].nhs;
   assign bus.vdrq        = pin_hist[cur].nvidrq;
   assign bus.vdak_rise   = ~pin_hist[prev].nvidak & pin_hist[cur].nvidak;
   assign bus.flybk_start = ~pin_hist[prev].flybk & pin_hist[cur].flybk;

endmodule

// ==== logic/register_mirror.sv ====
// VIDC register mirrors and host read multiplexer
// Palette and cursor exports, timing-change toggle flag
`include "vidc_settings.svh"

module register_mirror (
   input  logic                                                  clk,
   input  logic                                                  reset,
   sample_if.mirror                                              bus,
   input  logic                                                  hires,
   input  vidc_reg_pkg::reg_addr_t                               reg_sel,
   output vidc_reg_pkg::reg_data_t                               reg_rdata,
   output vidc_reg_pkg::colour_t [`VIDC_NUM_COLOURS-1:0]         palette,
   output vidc_reg_pkg::colour_t [`VIDC_NUM_CURSOR_COLOURS-1:0]  cursor_palette,
   output vidc_reg_pkg::cursor_x_t                               cursor_hstart,
   output vidc_reg_pkg::timing_t                                 cursor_vstart,
   output vidc_reg_pkg::timing_t                                 cursor_vend,
   output logic                                                  tregs_status,
   input  logic                                                  tregs_ack
);

   localparam int colour_idx_w = $clog2(`VIDC_NUM_COLOURS);

   vidc_reg_pkg::colour_t [`VIDC_NUM_COLOURS-1:0]        vplc;
   vidc_reg_pkg::colour_t [`VIDC_NUM_CURSOR_COLOURS-1:0] cplc;
   vidc_reg_pkg::colour_t                                bcr;
   vidc_reg_pkg::timing_t                                hcr;
   vidc_reg_pkg::timing_t                                vcr;
   vidc_reg_pkg::timing_t                                vdsr;
   vidc_reg_pkg::timing_t                                vcsr;
   vidc_reg_pkg::timing_t                                vcer;
   vidc_reg_pkg::hcursor_t                               hcsr;

   vidc_reg_pkg::colour_t  colour_in;
   vidc_reg_pkg::timing_t  timing_in;
   vidc_reg_pkg::hcursor_t hcsr_in;
   logic                   palette_wr;
   logic                   timing_wr;

   // Field positions within the 24-bit payload
   assign colour_in  = bus.reg_data[11:0];
   assign timing_in  = bus.reg_data[23:14];
   assign hcsr_in    = bus.reg_data[23:11];
   assign palette_wr = bus.reg_addr < vidc_reg_pkg::reg_addr_t'(`VIDC_NUM_COLOURS);
   assign timing_wr  = (bus.reg_addr == `VIDC_ADDR_HCR) || (bus.reg_addr == `VIDC_ADDR_VCR);

   ////////////////////////////////////////////////////////////////////////////
   // Write capture

   always_ff @(posedge clk) begin
      if (bus.reg_write) begin
         if (palette_wr)
            vplc[bus.reg_addr[colour_idx_w-1:0]] <= colour_in;
         case (bus.reg_addr)
            `VIDC_ADDR_BORDER:        bcr     <= colour_in;
            `VIDC_ADDR_CPLC1:         cplc[0] <= colour_in;
            `VIDC_ADDR_CPLC1 + 6'd1:  cplc[1] <= colour_in;
            `VIDC_ADDR_CPLC1 + 6'd2:  cplc[2] <= colour_in;
            `VIDC_ADDR_HCR:           hcr     <= timing_in;
            `VIDC_ADDR_HCSR:          hcsr    <= hcsr_in;
            `VIDC_ADDR_VCR:           vcr     <= timing_in;
            `VIDC_ADDR_VDSR:          vdsr    <= timing_in;
            `VIDC_ADDR_VCSR:          vcsr    <= timing_in;
            `VIDC_ADDR_VCER:          vcer    <= timing_in;
            default: ;                // Dropped and unmapped regs ignored
         endcase
      end
   end

   // Flips on a mode change, then waits for the host to catch up
   always_ff @(posedge clk) begin
      if (reset)
         tregs_status <= 1'b0;
      else if (bus.reg_write && timing_wr && (tregs_ack == tregs_status))
         tregs_status <= ~tregs_status;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Host reads return fields in their written position

   always_comb begin
      reg_rdata = '0;
      if (reg_sel < vidc_reg_pkg::reg_addr_t'(`VIDC_NUM_COLOURS))
         reg_rdata[11:0] = vplc[reg_sel[colour_idx_w-1:0]];
      case (reg_sel)
         `VIDC_ADDR_BORDER:        reg_rdata[11:0]  = bcr;
         `VIDC_ADDR_CPLC1:         reg_rdata[11:0]  = cplc[0];
         `VIDC_ADDR_CPLC1 + 6'd1:  reg_rdata[11:0]  = cplc[1];
         `VIDC_ADDR_CPLC1 + 6'd2:  reg_rdata[11:0]  = cplc[2];
         `VIDC_ADDR_HCR:           reg_rdata[23:14] = hcr;
         `VIDC_ADDR_HCSR:          reg_rdata[23:11] = hcsr;
         `VIDC_ADDR_VCR:           reg_rdata[23:14] = vcr;
         `VIDC_ADDR_VDSR:          reg_rdata[23:14] = vdsr;
         `VIDC_ADDR_VCSR:          reg_rdata[23:14] = vcsr;
         `VIDC_ADDR_VCER:          reg_rdata[23:14] = vcer;
         default: ;
      endcase
   end

   // Display exports
   assign palette        = vplc;
   assign cursor_palette = cplc;
   assign cursor_hstart  = hires ? hcsr[10:0] : hcsr[12:2];   // Lores counts half pixels
   assign cursor_vstart  = vcsr - vdsr;      // Relative to display start
   assign cursor_vend    = vcer - vdsr;

   // Write strobe edge detect gives isolated pulses
   assert property (@(posedge clk) disable iff (reset) bus.reg_write |=> !bus.reg_write);

endmodule

// ==== logic/dma_tracker.sv ====
// Video and cursor DMA burst tracking with beat strobes
// Per-frame burst counters latched at flyback
`include "vidc_settings.svh"

module dma_tracker (
   input  logic                       clk,
   input  logic                       reset,
   sample_if.tracker                  bus,
   output logic                       load_dma,
   output logic                       load_dma_cursor,
   output vidc_reg_pkg::bus_word_t    load_dma_data,
   output vidc_dma_pkg::frame_count_t fr_count,
   output vidc_dma_pkg::dma_count_t   video_dma_counter,
   output vidc_dma_pkg::dma_count_t   cursor_dma_counter
);

   vidc_dma_pkg::dma_state_t  state;
   vidc_dma_pkg::beat_count_t beat;
   vidc_dma_pkg::dma_count_t  video_count;     // Running counts this frame
   vidc_dma_pkg::dma_count_t  cursor_count;
   vidc_dma_pkg::dma_count_t  video_base;
   vidc_dma_pkg::dma_count_t  cursor_base;
   logic                      start_video;
   logic                      start_cursor;
   logic                      last_beat;

   // Request during hsync means cursor data
   assign start_video  = (state == vidc_dma_pkg::dma_idle) && !bus.vdrq && bus.hs;
   assign start_cursor = (state == vidc_dma_pkg::dma_idle) && !bus.vdrq && !bus.hs;
   assign last_beat    = beat == vidc_dma_pkg::beat_count_t'(`VIDC_DMA_BEATS - 1);

   ////////////////////////////////////////////////////////////////////////////
   // Burst FSM

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= vidc_dma_pkg::dma_idle;
         beat  <= '0;
      end else begin
         case (state)
            vidc_dma_pkg::dma_idle: begin
               if (start_video)
                  state <= vidc_dma_pkg::dma_video;
               else if (start_cursor)
                  state <= vidc_dma_pkg::dma_cursor;
            end
            default: begin
               if (bus.vdak_rise) begin
                  if (last_beat) begin         // MEMC always sends four
                     state <= vidc_dma_pkg::dma_idle;
                     beat  <= '0;
                  end else begin
                     beat <= beat + vidc_dma_pkg::beat_count_t'(1);
                  end
               end
            end
         endcase
      end
   end

   // A burst starting at flyback lands in the new frame
   assign video_base  = bus.flybk_start ? '0 : video_count;
   assign cursor_base = bus.flybk_start ? '0 : cursor_count;

   always_ff @(posedge clk) begin
      if (reset) begin
         video_count        <= '0;
         cursor_count       <= '0;
         video_dma_counter  <= '0;
         cursor_dma_counter <= '0;
         fr_count           <= '0;
      end else begin
         video_count  <= video_base + vidc_dma_pkg::dma_count_t'(start_video);
         cursor_count <= cursor_base + vidc_dma_pkg::dma_count_t'(start_cursor);
         if (bus.flybk_start) begin
            video_dma_counter  <= video_count;
            cursor_dma_counter <= cursor_count;
            fr_count           <= fr_count + vidc_dma_pkg::frame_count_t'(1);
         end
      end
   end

   assign load_dma        = (state == vidc_dma_pkg::dma_video) && bus.vdak_rise;
   assign load_dma_cursor = (state == vidc_dma_pkg::dma_cursor) && bus.vdak_rise;
   assign load_dma_data   = bus.dma_data;

   assert property (@(posedge clk) disable iff (reset) !(load_dma && load_dma_cursor));
   assert property (@(posedge clk) disable iff (reset)
      beat < vidc_dma_pkg::beat_count_t'(`VIDC_DMA_BEATS));

endmodule

// ==== logic/vidc_capture.sv ====
// VIDC capture top level
// Pin sampler feeding the register mirror and the DMA tracker
`include "vidc_settings.svh"

module vidc_capture (
   input  logic                                                  clk,
   input  logic                                                  reset,
   input  vidc_reg_pkg::bus_word_t                               vidc_d,
   input  logic                                                  vidc_nvidw,
   input  logic                                                  vidc_nhs,
   input  logic                                                  vidc_flybk,
   input  logic                                                  vidc_nvidrq,
   input  logic                                                  vidc_nvidak,
   input  logic                                                  conf_hires,
   input  vidc_reg_pkg::reg_addr_t                               vidc_reg_sel,
   input  logic                                                  tregs_status_ack,
   output vidc_reg_pkg::reg_data_t                               vidc_reg_rdata,
   output vidc_reg_pkg::colour_t [`VIDC_NUM_COLOURS-1:0]         vidc_palette,
   output vidc_reg_pkg::colour_t [`VIDC_NUM_CURSOR_COLOURS-1:0]  vidc_cursor_palette,
   output vidc_reg_pkg::cursor_x_t                               vidc_cursor_hstart,
   output vidc_reg_pkg::timing_t                                 vidc_cursor_vstart,
   output vidc_reg_pkg::timing_t                                 vidc_cursor_vend,
   output logic                                                  tregs_status,
   output vidc_dma_pkg::frame_count_t                            fr_count,
   output vidc_dma_pkg::dma_count_t                              video_dma_counter,
   output vidc_dma_pkg::dma_count_t                              cursor_dma_counter,
   output logic                                                  load_dma,
   output logic                                                  load_dma_cursor,
   output vidc_reg_pkg::bus_word_t                               load_dma_data
);

   sample_if sample_bus ();

   pin_sampler pin_sampler_inst (
      .clk         (clk),
      .reset       (reset),
      .vidc_d      (vidc_d),
      .vidc_nvidw  (vidc_nvidw),
      .vidc_nhs    (vidc_nhs),
      .vidc_flybk  (vidc_flybk),
      .vidc_nvidrq (vidc_nvidrq),
      .vidc_nvidak (vidc_nvidak),
      .bus         (sample_bus.sampler)
   );

   register_mirror register_mirror_inst (
      .clk            (clk),
      .reset          (reset),
      .bus            (sample_bus.mirror),
      .hires          (conf_hires),
      .reg_sel        (vidc_reg_sel),
      .reg_rdata      (vidc_reg_rdata),
      .palette        (vidc_palette),
      .cursor_palette (vidc_cursor_palette),
      .cursor_hstart  (vidc_cursor_hstart),
      .cursor_vstart  (vidc_cursor_vstart),
      .cursor_vend    (vidc_cursor_vend),
      .tregs_status   (tregs_status),
      .tregs_ack      (tregs_status_ack)
   );

   dma_tracker dma_tracker_inst (
      .clk                (clk),
      .reset              (reset),
      .bus                (sample_bus.tracker),
      .load_dma           (load_dma),
      .load_dma_cursor    (load_dma_cursor),
      .load_dma_data      (load_dma_data),
      .fr_count           (fr_count),
      .video_dma_counter  (video_dma_counter),
      .cursor_dma_counter (cursor_dma_counter)
   );

endmodule

// ==== tb/tb_clock.sv ====
// Testbench clock and reset generator

module tb_clock (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;       // Period 40
   end

   initial begin
      reset = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

// ==== tb/vidc_capture_tb.sv ====
// Testbench for the VIDC capture block
// Random register writes, DMA bursts and flybacks checked against a model
`include "vidc_settings.svh"

module vidc_capture_tb;

   logic                                                 clk;
   logic                                                 reset;
   vidc_reg_pkg::bus_word_t                              vidc_d;
   logic                                                 vidc_nvidw;
   logic                                                 vidc_nhs;
   logic                                                 vidc_flybk;
   logic                                                 vidc_nvidrq;
   logic                                                 vidc_nvidak;
   logic                                                 conf_hires;
   vidc_reg_pkg::reg_addr_t                              vidc_reg_sel;
   logic                                                 tregs_status_ack;
   vidc_reg_pkg::reg_data_t                              vidc_reg_rdata;
   vidc_reg_pkg::colour_t [`VIDC_NUM_COLOURS-1:0]        vidc_palette;
   vidc_reg_pkg::colour_t [`VIDC_NUM_CURSOR_COLOURS-1:0] vidc_cursor_palette;
   vidc_reg_pkg::cursor_x_t                              vidc_cursor_hstart;
   vidc_reg_pkg::timing_t                                vidc_cursor_vstart;
   vidc_reg_pkg::timing_t                                vidc_cursor_vend;
   logic                                                 tregs_status;
   vidc_dma_pkg::frame_count_t                           fr_count;
   vidc_dma_pkg::dma_count_t                             video_dma_counter;
   vidc_dma_pkg::dma_count_t                             cursor_dma_counter;
   logic                                                 load_dma;
   logic                                                 load_dma_cursor;
   vidc_reg_pkg::bus_word_t                              load_dma_data;

   // Reference model
   vidc_reg_pkg::reg_data_t    model_regs [64];     // Expected read value per address
   logic                       model_status;
   vidc_dma_pkg::dma_count_t   model_video;
   vidc_dma_pkg::dma_count_t   model_cursor;
   vidc_dma_pkg::frame_count_t model_frames;

   int                         video_strobes;
   int                         cursor_strobes;
   vidc_reg_pkg::bus_word_t    seen_data [$];       // Data of every strobe, in order

   vidc_reg_pkg::reg_addr_t    timing_regs [6] = '{`VIDC_ADDR_HCR, `VIDC_ADDR_HCSR,
      `VIDC_ADDR_VCR, `VIDC_ADDR_VDSR, `VIDC_ADDR_VCSR, `VIDC_ADDR_VCER};

   tb_clock tb_clock_inst (.clk(clk), .reset(reset));

   vidc_capture vidc_capture_inst (.*);

   // Strobes are stable between rising edges
   always @(negedge clk) begin
      if (!reset) begin
         if (load_dma)
            video_strobes++;
         if (load_dma_cursor)
            cursor_strobes++;
         if (load_dma || load_dma_cursor)
            seen_data.push_back(load_dma_data);
      end
   end

   task automatic end_with_failure();
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out waiting for %s", what);
      end_with_failure();
   endtask

   task automatic compare_value(input string name, input logic [191:0] expected,
                                input logic [191:0] actual);
      if (actual !== expected) begin
         $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
         end_with_failure();
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Register side

   task automatic model_write(input vidc_reg_pkg::reg_addr_t addr,
                              input vidc_reg_pkg::reg_data_t payload);
      if (addr < 6'h14)                               // Palette, border, cursor colours
         model_regs[addr] = {12'h000, payload[11:0]};
      else if (addr == `VIDC_ADDR_HCSR)
         model_regs[addr] = {payload[23:11], 11'h000};
      else if (addr inside {`VIDC_ADDR_HCR, `VIDC_ADDR_VCR, `VIDC_ADDR_VDSR,
                            `VIDC_ADDR_VCSR, `VIDC_ADDR_VCER}) begin
         model_regs[addr] = {payload[23:14], 14'h0000};
         if ((addr == `VIDC_ADDR_HCR || addr == `VIDC_ADDR_VCR) &&
             tregs_status_ack == model_status)
            model_status = ~model_status;
      end
   endtask

   task automatic write_reg(input vidc_reg_pkg::reg_addr_t addr,
                            input vidc_reg_pkg::reg_data_t payload);
      @(negedge clk);
      vidc_d = {addr, 2'($urandom), payload};
      @(negedge clk);
      vidc_nvidw = 1'b0;
      repeat (4) @(negedge clk);
      vidc_nvidw = 1'b1;
      repeat (8) @(negedge clk);                     // Settle
      model_write(addr, payload);
   endtask

   task automatic check_registers();
      logic [191:0]            exp_pal;
      logic [191:0]            exp_cpal;
      vidc_reg_pkg::hcursor_t  hcsr;
      vidc_reg_pkg::cursor_x_t exp_hstart;
      vidc_reg_pkg::timing_t   vdsr;
      vidc_reg_pkg::timing_t   exp_vstart;
      vidc_reg_pkg::timing_t   exp_vend;
      exp_pal  = '0;
      exp_cpal = '0;
      for (int a = 0; a < 64; a++) begin
         @(negedge clk);
         vidc_reg_sel = 6'(a);
         @(posedge clk);
         compare_value($sformatf("read of register 0x%02h", a),
                       192'(model_regs[a]), 192'(vidc_reg_rdata));
      end
      for (int i = 0; i < `VIDC_NUM_COLOURS; i++)
         exp_pal[i*12 +: 12] = model_regs[i][11:0];
      for (int i = 0; i < `VIDC_NUM_CURSOR_COLOURS; i++)
         exp_cpal[i*12 +: 12] = model_regs[`VIDC_ADDR_CPLC1 + i][11:0];
      hcsr       = model_regs[`VIDC_ADDR_HCSR][23:11];
      exp_hstart = conf_hires ? hcsr[10:0] : hcsr[12:2];
      vdsr       = model_regs[`VIDC_ADDR_VDSR][23:14];
      exp_vstart = model_regs[`VIDC_ADDR_VCSR][23:14] - vdsr;   // Wraps at 1024
      exp_vend   = model_regs[`VIDC_ADDR_VCER][23:14] - vdsr;
      compare_value("palette bus", exp_pal, 192'(vidc_palette));
      compare_value("cursor palette bus", exp_cpal, 192'(vidc_cursor_palette));
      compare_value("cursor hstart", 192'(exp_hstart), 192'(vidc_cursor_hstart));
      compare_value("cursor vstart", 192'(exp_vstart), 192'(vidc_cursor_vstart));
      compare_value("cursor vend", 192'(exp_vend), 192'(vidc_cursor_vend));
      compare_value("timing change flag", 192'(model_status), 192'(tregs_status));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // DMA side

   task automatic run_burst(input logic video);
      vidc_reg_pkg::bus_word_t beat_data [`VIDC_DMA_BEATS];
      int                      first;
      int                      video_before;
      int                      cursor_before;
      int                      cycles;
      first         = seen_data.size();
      video_before  = video_strobes;
      cursor_before = cursor_strobes;
      @(negedge clk);
      vidc_nhs    = video;                           // Low during hsync means cursor
      vidc_nvidrq = 1'b0;
      repeat (4) @(negedge clk);
      vidc_nvidrq = 1'b1;
      for (int b = 0; b < `VIDC_DMA_BEATS; b++) begin
         beat_data[b] = $urandom;
         vidc_d       = beat_data[b];
         @(negedge clk);
         vidc_nvidak = 1'b0;
         repeat (4) @(negedge clk);
         vidc_nvidak = 1'b1;
         repeat (4) @(negedge clk);
      end
      cycles = 0;
      while (seen_data.size() < first + `VIDC_DMA_BEATS) begin
         if (cycles == 40)
            report_timeout("the fourth DMA strobe of a burst");
         @(negedge clk);
         cycles++;
      end
      repeat (4) @(negedge clk);                     // Catch stray strobes
      compare_value(video ? "video strobes" : "cursor strobes", 192'(`VIDC_DMA_BEATS),
         192'(video ? video_strobes - video_before : cursor_strobes - cursor_before));
      compare_value(video ? "stray cursor strobes" : "stray video strobes", 192'(0),
         192'(video ? cursor_strobes - cursor_before : video_strobes - video_before));
      for (int b = 0; b < `VIDC_DMA_BEATS; b++)
         compare_value($sformatf("beat %0d data", b), 192'(beat_data[b]),
                       192'(seen_data[first + b]));
      if (video)
         model_video++;
      else
         model_cursor++;
   endtask

   task automatic run_flyback();
      int cycles;
      model_frames = model_frames + 4'd1;            // Wraps at 16
      @(negedge clk);
      vidc_flybk = 1'b1;
      repeat (4) @(negedge clk);
      vidc_flybk = 1'b0;
      cycles = 0;
      while (fr_count !== model_frames) begin
         if (cycles == 40)
            report_timeout("the frame counter to advance");
         @(negedge clk);
         cycles++;
      end
      compare_value("video bursts per frame", 192'(model_video), 192'(video_dma_counter));
      compare_value("cursor bursts per frame", 192'(model_cursor), 192'(cursor_dma_counter));
      model_video  = '0;
      model_cursor = '0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      vidc_reg_pkg::reg_addr_t addr;
      int                      cycles;
      int                      n_bursts;
      void'($urandom(91164));
      vidc_d           = '0;
      vidc_nvidw       = 1'b1;
      vidc_nhs         = 1'b1;
      vidc_flybk       = 1'b0;
      vidc_nvidrq      = 1'b1;
      vidc_nvidak      = 1'b1;
      conf_hires       = 1'b0;
      vidc_reg_sel     = '0;
      tregs_status_ack = 1'b0;
      for (int a = 0; a < 64; a++)
         model_regs[a] = '0;
      model_status  = 1'b0;
      model_video   = '0;
      model_cursor  = '0;
      model_frames  = '0;
      video_strobes  = 0;
      cursor_strobes = 0;

      @(posedge clk);
      cycles = 0;
      while (reset) begin
         if (cycles == 20)
            report_timeout("reset to be released");
         @(posedge clk);
         cycles++;
      end
      @(negedge clk);
      compare_value("status after reset", 192'(0), 192'(tregs_status));
      compare_value("frame count after reset", 192'(0), 192'(fr_count));
      compare_value("video counter after reset", 192'(0), 192'(video_dma_counter));
      compare_value("cursor counter after reset", 192'(0), 192'(cursor_dma_counter));
      compare_value("video strobe after reset", 192'(0), 192'(load_dma));
      compare_value("cursor strobe after reset", 192'(0), 192'(load_dma_cursor));

      // Mirrors come up unknown so each kept register gets a value first
      for (int a = 0; a < 'h14; a++)
         write_reg(6'(a), 24'($urandom));
      foreach (timing_regs[i])
         write_reg(timing_regs[i], 24'($urandom));
      check_registers();

      for (int n = 0; n < 40; n++) begin
         @(negedge clk);
         tregs_status_ack = 1'($urandom);
         conf_hires       = 1'($urandom);
         addr = 6'($urandom);
         if ($urandom_range(0, 1) == 0)
            addr = 6'h20 + 6'($urandom_range(0, 15));   // Timing block holds kept and dropped
         write_reg(addr, 24'($urandom));
         check_registers();
      end

      for (int f = 0; f < 20; f++) begin
         n_bursts = $urandom_range(0, 5);
         for (int b = 0; b < n_bursts; b++)
            run_burst(1'($urandom));
         run_flyback();
      end

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+logic
logic/vidc_reg_pkg.sv
logic/vidc_dma_pkg.sv
logic/sample_if.sv
logic/pin_sampler.sv
logic/register_mirror.sv
logic/dma_tracker.sv
logic/vidc_capture.sv
tb/tb_clock.sv
tb/vidc_capture_tb.sv

// ==== Makefile ====
# Verilator build and run for the VIDC capture testbench

VERILATOR ?= verilator
TOP       ?= vidc_capture_tb
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat list.f))
HEADERS := $(wildcard logic/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): list.f $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f list.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
